// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/icache_geom_pkg.sv
      - verilog/icache_ctrl_pkg.sv
      - verilog/icache_req_stage.sv
      - verilog/icache_way_arrays.sv
      - verilog/icache_lookup.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/icache_checker.sv
      - bench/tb_icache.sv

// File: bench/icache_checker.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_rready,
    input  logic [63:0] i_rdata,
    input  logic [31:0] i_pc,
    input  logic [6:0]  i_exception,
    input  logic [31:0] i_badv,
    input  logic        i_mem_rvalid,
    input  logic        i_mem_rready,
    input  logic [31:0] i_mem_raddr,
    input  logic [7:0]  i_mem_rlen,
    input  logic        i_cacop_ready,
    input  logic        i_cacop_done,
    input  logic        i_test_end,
    input  int          i_test_id,
    input  logic [31:0] i_exp_addr,
    input  logic        i_exp_uncache,
    input  logic        i_exp_mem,
    input  int          i_exp_resp,
    input  logic        i_exp_cacop,
    output int          o_errors,
    output int          o_tests,
    output int          o_failed
);

    localparam logic [31:0] MEM_KEY = 32'h5a5a_0000;

    int n_resp;
    int n_mem;
    int n_ready;
    int n_done;
    int test_errs;

    // memory word = byte address ^ key, low word at the lower address
    function automatic logic [63:0] expected_dword(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
        test_errs++;
        o_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("test %0d: %s", i_test_id, msg);
        test_errs++;
        o_errors++;
    endtask

    task automatic clear_counts();
        n_resp    = 0;
        n_mem     = 0;
        n_ready   = 0;
        n_done    = 0;
        test_errs = 0;
    endtask

    task automatic check_response();
        logic [31:0] pc_exp;
        pc_exp = i_exp_addr + 32'(n_resp) * 32'd8; // bursts step one doubleword
        n_resp++;
        if (i_pc !== pc_exp) report_mismatch("o_pc", i_pc, pc_exp);
        if (pc_exp[1:0] != 2'b00) begin
            if (i_exception !== `ICACHE_EXP_ADEF)
                report_mismatch("o_exception", i_exception, `ICACHE_EXP_ADEF);
            if (i_badv !== pc_exp) report_mismatch("o_badv", i_badv, pc_exp);
        end else begin
            if (i_exception !== 7'h00) report_mismatch("o_exception", i_exception, 7'h00);
            if (i_badv !== 32'h0) report_mismatch("o_badv", i_badv, 32'h0);
            if (i_rdata !== expected_dword(pc_exp))
                report_mismatch("o_rdata", i_rdata, expected_dword(pc_exp));
        end
    endtask

    task automatic check_mem_request();
        logic [31:0] addr_exp;
        logic [7:0]  len_exp;
        n_mem++;
        if (i_exp_uncache) begin
            addr_exp = {i_exp_addr[31:3], 3'b000};
            len_exp  = `ICACHE_UNCACHE_LEN;
        end else begin
            addr_exp = {i_exp_addr[31:6], 6'b000000}; // 64-byte line
            len_exp  = `ICACHE_LINE_LEN;
        end
        if (i_mem_raddr !== addr_exp) report_mismatch("o_mem_raddr", i_mem_raddr, addr_exp);
        if (i_mem_rlen !== len_exp) report_mismatch("o_mem_rlen", i_mem_rlen, len_exp);
    endtask

    task automatic finish_test();
        if (n_mem != int'(i_exp_mem))
            report_failure($sformatf("expected %0d memory requests, saw %0d",
                                     int'(i_exp_mem), n_mem));
        if (n_resp != i_exp_resp)
            report_failure($sformatf("expected %0d fetch responses, saw %0d",
                                     i_exp_resp, n_resp));
        if (n_ready != int'(i_exp_cacop) || n_done != int'(i_exp_cacop))
            report_failure($sformatf("cache op ready pulsed %0d times, done %0d times",
                                     n_ready, n_done));
        o_tests++;
        if (test_errs != 0) o_failed++;
        $display("test %0d at %h: %s", i_test_id, i_exp_addr,
                 (test_errs == 0) ? "ok" : "failed");
        clear_counts();
    endtask

    // sampled on the rising edge, inputs move on the falling one
    always @(posedge clk) begin
        if (!rstn) begin
            clear_counts();
            o_errors = 0;
            o_tests  = 0;
            o_failed = 0;
        end else begin
            if (i_rready) check_response();
            if (i_mem_rvalid && i_mem_rready) check_mem_request();
            if (i_cacop_ready) n_ready++;
            if (i_cacop_done) n_done++;
            if (i_test_end) finish_test();
        end
    end

endmodule

// File: bench/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;
    import icache_ctrl_pkg::*;

    localparam int N_ENTRIES   = 19;
    localparam int CYCLE_LIMIT = N_ENTRIES * 12;
    localparam int K_FETCH     = 0;
    localparam int K_UNC       = 1;
    localparam int K_CACOP     = 2;
    localparam int K_BURST     = 3;   // eight doublewords of one line, back to back
    localparam logic [31:0] MEM_KEY = 32'h5a5a_0000;
    localparam logic [31:0] LINE_A  = 32'h0000_1040; // A, B and C all map to set 1
    localparam logic [31:0] LINE_B  = 32'h0000_2040;
    localparam logic [31:0] LINE_C  = 32'h0000_3040;

    logic         clk;
    logic         rstn;
    logic         i_rvalid;
    logic [31:0]  i_raddr;
    logic         i_uncache;
    logic         i_cacop_en;
    cacop_op_t    i_cacop_code;
    logic         i_mem_rready;
    logic [511:0] i_mem_rdata;
    logic         o_rready;
    logic [63:0]  o_rdata;
    logic [31:0]  o_pc;
    logic [6:0]   o_exception;
    logic [31:0]  o_badv;
    logic         o_mem_rvalid;
    logic [31:0]  o_mem_raddr;
    logic [7:0]   o_mem_rlen;
    logic         o_cacop_ready;
    logic         o_cacop_done;

    // expectations handed to the checker
    logic         test_end;
    int           test_id;
    logic [31:0]  exp_addr;
    logic         exp_uncache;
    logic         exp_mem;
    int           exp_resp;
    logic         exp_cacop;
    int           errors;
    int           tests;
    int           failed;

    integer       seed = 32'hbb52_f33a;
    int           cycles;
    int           mem_wait;
    logic         mem_busy;
    int           n_loaded;

    int           tbl_kind [N_ENTRIES];
    logic [31:0]  tbl_addr [N_ENTRIES];
    cacop_op_t    tbl_op [N_ENTRIES];
    logic         tbl_mem [N_ENTRIES];  // memory request expected

    icache_top dut (
        .clk(clk), .rstn(rstn), .i_rvalid(i_rvalid), .i_raddr(i_raddr),
        .i_uncache(i_uncache), .i_cacop_en(i_cacop_en), .i_cacop_code(i_cacop_code),
        .i_mem_rready(i_mem_rready), .i_mem_rdata(i_mem_rdata), .o_rready(o_rready),
        .o_rdata(o_rdata), .o_pc(o_pc), .o_exception(o_exception), .o_badv(o_badv),
        .o_mem_rvalid(o_mem_rvalid), .o_mem_raddr(o_mem_raddr), .o_mem_rlen(o_mem_rlen),
        .o_cacop_ready(o_cacop_ready), .o_cacop_done(o_cacop_done)
    );

    icache_checker u_checker (
        .clk(clk), .rstn(rstn), .i_rready(o_rready), .i_rdata(o_rdata), .i_pc(o_pc),
        .i_exception(o_exception), .i_badv(o_badv), .i_mem_rvalid(o_mem_rvalid),
        .i_mem_rready(i_mem_rready), .i_mem_raddr(o_mem_raddr), .i_mem_rlen(o_mem_rlen),
        .i_cacop_ready(o_cacop_ready), .i_cacop_done(o_cacop_done), .i_test_end(test_end),
        .i_test_id(test_id), .i_exp_addr(exp_addr), .i_exp_uncache(exp_uncache),
        .i_exp_mem(exp_mem), .i_exp_resp(exp_resp), .i_exp_cacop(exp_cacop),
        .o_errors(errors), .o_tests(tests), .o_failed(failed)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic add_entry(input int kind, input logic [31:0] addr, input cacop_op_t op,
                             input logic mem);
        tbl_kind[n_loaded] = kind;
        tbl_addr[n_loaded] = addr;
        tbl_op[n_loaded]   = op;
        tbl_mem[n_loaded]  = mem;
        n_loaded++;
    endtask

    task automatic load_table();
        n_loaded = 0;
        add_entry(K_FETCH, LINE_A + 32'h08, STORE_TAG, 1'b1); // cold miss, fills way 1
        add_entry(K_FETCH, LINE_A + 32'h10, STORE_TAG, 1'b0);
        add_entry(K_BURST, LINE_A, STORE_TAG, 1'b0);
        add_entry(K_FETCH, LINE_B + 32'h18, STORE_TAG, 1'b1);
        add_entry(K_FETCH, LINE_A + 32'h20, STORE_TAG, 1'b0);
        add_entry(K_FETCH, LINE_C + 32'h28, STORE_TAG, 1'b1); // B is least recent
        add_entry(K_FETCH, LINE_A + 32'h30, STORE_TAG, 1'b0);
        add_entry(K_FETCH, LINE_B + 32'h38, STORE_TAG, 1'b1);
        add_entry(K_UNC, 32'h0000_5a0c, STORE_TAG, 1'b1);
        add_entry(K_UNC, 32'h0000_5a0c, STORE_TAG, 1'b1);    // never allocated
        add_entry(K_FETCH, LINE_A + 32'h02, STORE_TAG, 1'b0); // misaligned
        add_entry(K_CACOP, LINE_A, HIT_INV, 1'b0);
        add_entry(K_FETCH, LINE_A + 32'h08, STORE_TAG, 1'b1); // refilled into way 1
        add_entry(K_CACOP, LINE_A + 32'h01, INDEX_INV, 1'b0);
        add_entry(K_FETCH, LINE_A + 32'h10, STORE_TAG, 1'b1); // refilled into way 0
        add_entry(K_CACOP, LINE_A, STORE_TAG, 1'b0);
        add_entry(K_FETCH, LINE_A + 32'h18, STORE_TAG, 1'b1);
        add_entry(K_FETCH, 32'h0001_0ffc, STORE_TAG, 1'b1);   // last set, top slot
        add_entry(K_FETCH, 32'h0001_0ff8, STORE_TAG, 1'b0);
    endtask

    // uncached replies carry only the addressed doubleword, at the top
    function automatic logic [511:0] build_line(input logic [31:0] addr,
                                                input logic [7:0] len);
        logic [511:0] line;
        line = '0;
        if (len == 8'd1) begin
            line[511:448] = {(addr + 32'd4) ^ MEM_KEY, addr ^ MEM_KEY};
        end else begin
            for (int i = 0; i < 16; i++)
                line[32*i +: 32] = (addr + 32'(4 * i)) ^ MEM_KEY;
        end
        return line;
    endfunction

    // memory model, 1 to 4 cycles to answer
    always @(negedge clk) begin
        if (!rstn) begin
            i_mem_rready = 1'b0;
            mem_busy     = 1'b0;
        end else if (i_mem_rready) begin
            i_mem_rready = 1'b0;
        end else if (o_mem_rvalid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = 1 + ($unsigned($random(seed)) % 4);
            end
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                i_mem_rdata  = build_line(o_mem_raddr, o_mem_rlen);
                i_mem_rready = 1'b1;
                mem_busy     = 1'b0;
            end
        end
    end

    task automatic single_fetch(input logic [31:0] addr, input logic unc);
        @(negedge clk);
        i_raddr   = addr;
        i_uncache = unc;
        i_rvalid  = 1'b1;
        @(posedge clk);   // accepted from IDLE
        @(negedge clk);
        i_rvalid = 1'b0;
        do begin
            @(posedge clk);
        end while (!o_rready);
    endtask

    task automatic burst_fetch(input logic [31:0] base);
        int got;
        got = 0;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            i_raddr   = base + 32'(8 * k);
            i_uncache = 1'b0;
            i_rvalid  = 1'b1;
            @(posedge clk);
            if (o_rready) got++;
        end
        @(negedge clk);
        i_rvalid = 1'b0;
        while (got < 8) begin
            @(posedge clk);
            if (o_rready) got++;
        end
    endtask

    task automatic cache_op(input logic [31:0] addr, input cacop_op_t op);
        @(negedge clk);
        i_raddr      = addr;
        i_cacop_code = op;
        i_cacop_en   = 1'b1;
        @(posedge clk);
        @(negedge clk);
        i_cacop_en = 1'b0;
        do begin
            @(posedge clk);
        end while (!o_cacop_done);
    endtask

    task automatic close_test();
        @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = 32'h0;
        i_uncache    = 1'b0;
        i_cacop_en   = 1'b0;
        i_cacop_code = STORE_TAG;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        test_end     = 1'b0;
        test_id      = 0;
        exp_addr     = 32'h0;
        exp_uncache  = 1'b0;
        exp_mem      = 1'b0;
        exp_resp     = 0;
        exp_cacop    = 1'b0;
        cycles       = 0;
        mem_wait     = 0;
        mem_busy     = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            test_id     = i;
            exp_addr    = tbl_addr[i];
            exp_uncache = (tbl_kind[i] == K_UNC);
            exp_mem     = tbl_mem[i];
            exp_cacop   = (tbl_kind[i] == K_CACOP);
            exp_resp    = (tbl_kind[i] == K_BURST) ? 8 : (tbl_kind[i] == K_CACOP) ? 0 : 1;
            case (tbl_kind[i])
                K_FETCH: single_fetch(tbl_addr[i], 1'b0);
                K_UNC:   single_fetch(tbl_addr[i], 1'b1);
                K_CACOP: cache_op(tbl_addr[i], tbl_op[i]);
                default: burst_fetch(tbl_addr[i]);
            endcase
            close_test();
        end
        $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && tests == N_ENTRIES) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/icache_geom_pkg.sv
verilog/icache_ctrl_pkg.sv
verilog/icache_req_stage.sv
verilog/icache_way_arrays.sv
verilog/icache_lookup.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
bench/icache_checker.sv
bench/tb_icache.sv

// File: verilog/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry, 2 ways x 64 sets x 64 bytes
`define ICACHE_INDEX_WIDTH  6
`define ICACHE_OFFSET_WIDTH 6
`define ICACHE_TAG_WIDTH    20

// data widths
`define ICACHE_LINE_BITS    512 // one line per memory return
`define ICACHE_FETCH_BITS   64  // two instructions per fetch

// memory burst lengths, beats minus one
`define ICACHE_LINE_LEN     8'd15
`define ICACHE_UNCACHE_LEN  8'd1

// misaligned fetch
`define ICACHE_EXP_ADEF     7'h08

`endif

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        i_rvalid,
    input  logic                        i_cacop_en,
    input  logic                        i_req_uncache,
    input  logic                        i_req_cacop,
    input  icache_ctrl_pkg::cacop_op_t  i_req_op,
    input  logic                        i_misaligned,
    input  logic                        i_hit,
    input  icache_geom_pkg::way_sel_t   i_hit_way,
    input  icache_geom_pkg::way_sel_t   i_fill_way,
    input  icache_geom_pkg::addr_t      i_req_addr,
    input  logic                        i_mem_rready,
    input  icache_geom_pkg::line_t      i_mem_rdata,
    output logic                        o_load,
    output logic                        o_rready,
    output logic                        o_cacop_ready,
    output logic                        o_cacop_done,
    output icache_geom_pkg::way_sel_t   o_way_we,
    output logic                        o_tag_clear,
    output logic                        o_use_ret,
    output logic                        o_lru_we,
    output icache_geom_pkg::way_sel_t   o_visit_way,
    output icache_geom_pkg::line_t      o_ret_line,
    output logic                        o_mem_rvalid,
    output icache_geom_pkg::addr_t      o_mem_raddr,
    output logic [7:0]                  o_mem_rlen,
    output icache_ctrl_pkg::exc_t       o_exception,
    output icache_geom_pkg::addr_t      o_badv
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    state_t state;
    state_t next_state;
    line_t  ret_buf;
    logic   free;     // IDLE or REFILL, a new request may enter
    logic   hit_done; // cached hit answered in LOOKUP

    assign free     = (state == IDLE) || (state == REFILL);
    assign hit_done = (state == LOOKUP) && i_hit && !i_req_uncache && !i_misaligned;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == MISS && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, REFILL: begin
                if (i_cacop_en)    next_state = CACOP; // op wins over a fetch
                else if (i_rvalid) next_state = LOOKUP;
                else               next_state = IDLE;
            end
            LOOKUP: begin
                if (i_misaligned)       next_state = IDLE;
                else if (i_req_uncache) next_state = MISS;
                else if (i_hit)         next_state = (i_rvalid && !i_cacop_en) ? LOOKUP : IDLE;
                else                    next_state = MISS;
            end
            MISS:    next_state = i_mem_rready ? REFILL : MISS; // hold on stall
            CACOP:   next_state = REFILL;
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        o_load        = 1'b0;
        o_rready      = 1'b0;
        o_cacop_ready = 1'b0;
        o_cacop_done  = 1'b0;
        o_way_we      = 2'b00;
        o_tag_clear   = 1'b0;
        o_use_ret     = 1'b0;
        o_lru_we      = 1'b0;
        o_visit_way   = 2'b00;
        if (free) begin
            o_load        = i_cacop_en || i_rvalid;
            o_cacop_ready = i_cacop_en;
        end
        case (state)
            LOOKUP: begin
                o_rready    = i_misaligned || hit_done;
                o_load      = hit_done && i_rvalid && !i_cacop_en;
                o_lru_we    = hit_done;
                o_visit_way = i_hit_way;
            end
            REFILL: begin
                o_use_ret    = 1'b1;
                o_rready     = !i_req_cacop;
                o_cacop_done = i_req_cacop;
                if (!i_req_uncache && !i_req_cacop) begin
                    o_way_we    = i_fill_way;
                    o_lru_we    = 1'b1;
                    o_visit_way = i_fill_way;
                end
            end
            CACOP: begin
                o_tag_clear = 1'b1;
                // hit-invalidate of an absent line clears nothing
                o_way_we    = (i_req_op == HIT_INV && !i_hit) ? 2'b00 : i_fill_way;
            end
            default: ;
        endcase
    end

    assign o_ret_line   = ret_buf;
    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = i_req_uncache ? {i_req_addr[31:3], 3'b000}
                                        : {i_req_addr[31:`ICACHE_OFFSET_WIDTH],
                                           {`ICACHE_OFFSET_WIDTH{1'b0}}};
    assign o_mem_rlen   = i_req_uncache ? `ICACHE_UNCACHE_LEN : `ICACHE_LINE_LEN;

    assign o_exception = (state == LOOKUP && i_misaligned) ? `ICACHE_EXP_ADEF : 7'h00;
    assign o_badv      = (o_exception != 7'h00) ? i_req_addr : 32'h0;

    // request fields must not move under a pending memory read
    assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> $stable(o_mem_raddr) && $stable(o_mem_rlen));

endmodule

// File: verilog/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // main cache FSM
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        MISS   = 3'd2,
        REFILL = 3'd3,
        CACOP  = 3'd4  // tag clear, finishes through REFILL
    } state_t;

    // cache-op codes from the pipeline
    typedef enum logic [1:0] {
        STORE_TAG = 2'd0,
        INDEX_INV = 2'd1,
        HIT_INV   = 2'd2
    } cacop_op_t;

    typedef logic [6:0] exc_t;

endpackage

// File: verilog/icache_geom_pkg.sv
`include "icache_consts.svh"

package icache_geom_pkg;

    // fetch address, treated as physical
    typedef logic [31:0] addr_t;

    // address fields
    typedef logic [`ICACHE_TAG_WIDTH-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;

    // storage and fetch widths
    typedef logic [`ICACHE_LINE_BITS-1:0]  line_t;
    typedef logic [`ICACHE_FETCH_BITS-1:0] fetch_t;

    // one-hot, bit 0 is way 0
    typedef logic [1:0] way_sel_t;

endpackage

// File: verilog/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup (
    input  logic                        clk,
    input  logic                        rstn,
    input  icache_geom_pkg::addr_t      i_req_addr,
    input  logic                        i_req_uncache,
    input  logic                        i_req_cacop,
    input  icache_ctrl_pkg::cacop_op_t  i_req_op,
    input  icache_geom_pkg::tag_t       i_tag0,
    input  icache_geom_pkg::tag_t       i_tag1,
    input  icache_geom_pkg::way_sel_t   i_valid,
    input  icache_geom_pkg::line_t      i_line0,
    input  icache_geom_pkg::line_t      i_line1,
    input  icache_geom_pkg::line_t      i_ret_line,
    input  logic                        i_use_ret,
    input  logic                        i_lru_we,
    input  icache_geom_pkg::way_sel_t   i_visit_way,
    output logic                        o_hit,
    output icache_geom_pkg::way_sel_t   o_hit_way,
    output icache_geom_pkg::way_sel_t   o_fill_way,
    output icache_geom_pkg::fetch_t     o_rdata
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    tag_t     req_tag;
    index_t   req_index;
    way_sel_t hit;
    line_t    src_line;
    fetch_t   slot;
    logic [(1 << `ICACHE_INDEX_WIDTH)-1:0] lru_bits; // set: way 1 visited last

    assign req_tag   = i_req_addr[31 -: `ICACHE_TAG_WIDTH];
    assign req_index = i_req_addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];

    assign hit[0]    = i_valid[0] && (i_tag0 == req_tag);
    assign hit[1]    = i_valid[1] && (i_tag1 == req_tag);
    assign o_hit     = |hit;
    assign o_hit_way = hit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (i_lru_we) begin
            lru_bits[req_index] <= (i_visit_way == 2'b10);
        end
    end

    // way to fill, or the way a cache op clears
    always_comb begin
        if (i_req_cacop && i_req_op == HIT_INV) begin
            o_fill_way = hit;
        end else if (i_req_cacop) begin
            o_fill_way = i_req_addr[0] ? 2'b10 : 2'b01; // index-type op
        end else begin
            o_fill_way = lru_bits[req_index] ? 2'b01 : 2'b10;
        end
    end

    assign src_line = i_use_ret ? i_ret_line : (hit[1] ? i_line1 : i_line0);
    assign slot = src_line[i_req_addr[`ICACHE_OFFSET_WIDTH-1:3] * `ICACHE_FETCH_BITS
                           +: `ICACHE_FETCH_BITS];

    // uncached doubleword comes back in the top slot
    assign o_rdata = i_req_uncache ? i_ret_line[`ICACHE_LINE_BITS-1 -: `ICACHE_FETCH_BITS]
                                   : slot;

endmodule

// File: verilog/icache_req_stage.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_req_stage (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        i_load,
    input  icache_geom_pkg::addr_t      i_raddr,
    input  logic                        i_uncache,
    input  logic                        i_cacop_en,
    input  icache_ctrl_pkg::cacop_op_t  i_cacop_code,
    output icache_geom_pkg::addr_t      o_req_addr,
    output logic                        o_req_uncache,
    output logic                        o_req_cacop,
    output icache_ctrl_pkg::cacop_op_t  o_req_op,
    output logic                        o_misaligned,
    output icache_geom_pkg::index_t     o_rd_index
);

    // flags of the buffered request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_req_uncache <= 1'b0;
            o_req_cacop   <= 1'b0;
        end else if (i_load) begin
            o_req_uncache <= i_uncache;
            o_req_cacop   <= i_cacop_en;
        end
    end

    // address and op code
    always_ff @(posedge clk) begin
        if (i_load) begin
            o_req_addr <= i_raddr;
            o_req_op   <= i_cacop_code;
        end
    end

    // a cache op carries an index/way address, not a fetch pc
    assign o_misaligned = (o_req_addr[1:0] != 2'b00) && !o_req_cacop;

    // arrays read with the incoming index, data is ready in the next state
    assign o_rd_index = i_raddr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        i_rvalid,
    input  icache_geom_pkg::addr_t      i_raddr,
    input  logic                        i_uncache,
    input  logic                        i_cacop_en,
    input  icache_ctrl_pkg::cacop_op_t  i_cacop_code,
    input  logic                        i_mem_rready,
    input  icache_geom_pkg::line_t      i_mem_rdata,
    output logic                        o_rready,
    output icache_geom_pkg::fetch_t     o_rdata,
    output icache_geom_pkg::addr_t      o_pc,
    output icache_ctrl_pkg::exc_t       o_exception,
    output icache_geom_pkg::addr_t      o_badv,
    output logic                        o_mem_rvalid,
    output icache_geom_pkg::addr_t      o_mem_raddr,
    output logic [7:0]                  o_mem_rlen,
    output logic                        o_cacop_ready,
    output logic                        o_cacop_done
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    addr_t     req_addr;
    logic      req_uncache, req_cacop, misaligned, load;
    cacop_op_t req_op;
    index_t    rd_index;
    tag_t      tag0, tag1;
    way_sel_t  valid, hit_way, fill_way, way_we, visit_way;
    line_t     line0, line1, ret_line;
    logic      hit, tag_clear, use_ret, lru_we;

    assign o_pc = req_addr;

    icache_req_stage u_req (
        .clk(clk), .rstn(rstn), .i_load(load), .i_raddr(i_raddr), .i_uncache(i_uncache),
        .i_cacop_en(i_cacop_en), .i_cacop_code(i_cacop_code), .o_req_addr(req_addr),
        .o_req_uncache(req_uncache), .o_req_cacop(req_cacop), .o_req_op(req_op),
        .o_misaligned(misaligned), .o_rd_index(rd_index)
    );

    icache_way_arrays u_arrays (
        .clk(clk), .rstn(rstn), .i_rd_index(rd_index),
        .i_wr_index(req_addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH]),
        .i_way_we(way_we), .i_tag_clear(tag_clear),
        .i_wr_tag(req_addr[31 -: `ICACHE_TAG_WIDTH]), .i_wr_line(ret_line),
        .o_tag0(tag0), .o_tag1(tag1), .o_valid(valid), .o_line0(line0), .o_line1(line1)
    );

    icache_lookup u_lookup (
        .clk(clk), .rstn(rstn), .i_req_addr(req_addr), .i_req_uncache(req_uncache),
        .i_req_cacop(req_cacop), .i_req_op(req_op), .i_tag0(tag0), .i_tag1(tag1),
        .i_valid(valid), .i_line0(line0), .i_line1(line1), .i_ret_line(ret_line),
        .i_use_ret(use_ret), .i_lru_we(lru_we), .i_visit_way(visit_way), .o_hit(hit),
        .o_hit_way(hit_way), .o_fill_way(fill_way), .o_rdata(o_rdata)
    );

    icache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .i_rvalid(i_rvalid), .i_cacop_en(i_cacop_en),
        .i_req_uncache(req_uncache), .i_req_cacop(req_cacop), .i_req_op(req_op),
        .i_misaligned(misaligned), .i_hit(hit), .i_hit_way(hit_way), .i_fill_way(fill_way),
        .i_req_addr(req_addr), .i_mem_rready(i_mem_rready), .i_mem_rdata(i_mem_rdata),
        .o_load(load), .o_rready(o_rready), .o_cacop_ready(o_cacop_ready),
        .o_cacop_done(o_cacop_done), .o_way_we(way_we), .o_tag_clear(tag_clear),
        .o_use_ret(use_ret), .o_lru_we(lru_we), .o_visit_way(visit_way),
        .o_ret_line(ret_line), .o_mem_rvalid(o_mem_rvalid), .o_mem_raddr(o_mem_raddr),
        .o_mem_rlen(o_mem_rlen), .o_exception(o_exception), .o_badv(o_badv)
    );

endmodule

// File: verilog/icache_way_arrays.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_way_arrays (
    input  logic                     clk,
    input  logic                     rstn,
    input  icache_geom_pkg::index_t  i_rd_index,
    input  icache_geom_pkg::index_t  i_wr_index,
    input  icache_geom_pkg::way_sel_t i_way_we,
    input  logic                     i_tag_clear,
    input  icache_geom_pkg::tag_t    i_wr_tag,
    input  icache_geom_pkg::line_t   i_wr_line,
    output icache_geom_pkg::tag_t    o_tag0,
    output icache_geom_pkg::tag_t    o_tag1,
    output icache_geom_pkg::way_sel_t o_valid,
    output icache_geom_pkg::line_t   o_line0,
    output icache_geom_pkg::line_t   o_line1
);
    import icache_geom_pkg::*;

    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    tag_t  rd_tag [2];
    line_t rd_line [2];
    logic  same_set;

    assign same_set = (i_rd_index == i_wr_index);

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t       tag_mem [SETS];
        line_t      line_mem [SETS];
        logic [SETS-1:0] valid_bits;
        logic       fill;

        assign fill = i_way_we[w] && !i_tag_clear; // clear touches valid only

        always_ff @(posedge clk) begin
            if (fill) begin
                tag_mem[i_wr_index]  <= i_wr_tag;
                line_mem[i_wr_index] <= i_wr_line;
            end
            // write-first, a fetch right after refill sees the new line
            rd_tag[w]  <= (fill && same_set) ? i_wr_tag : tag_mem[i_rd_index];
            rd_line[w] <= (fill && same_set) ? i_wr_line : line_mem[i_rd_index];
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_bits <= '0;
                o_valid[w] <= 1'b0;
            end else begin
                if (i_way_we[w]) begin
                    valid_bits[i_wr_index] <= !i_tag_clear;
                end
                o_valid[w] <= (i_way_we[w] && same_set) ? !i_tag_clear
                                                        : valid_bits[i_rd_index];
            end
        end
    end

    assign o_tag0  = rd_tag[0];
    assign o_tag1  = rd_tag[1];
    assign o_line0 = rd_line[0];
    assign o_line1 = rd_line[1];

    // fill and cache op both target a single way
    assert property (@(posedge clk) disable iff (!rstn) $onehot0(i_way_we));

endmodule
